//--- hdl/dma_map_pkg.sv
package dma_map_pkg;

  // Wishbone bus widths.
  localparam int WB_AW = 16;
  localparam int WB_DW = 16;

  // FROM image.
  localparam logic [WB_AW-1:0] FROM_ACM_A = 16'd0;
  localparam logic [WB_AW-1:0] FROM_LC_A = 16'd40;

  // Level checker and ACM tables.
  localparam logic [WB_AW-1:0] LC_THRESHS_A = 16'd128;
  localparam logic [WB_AW-1:0] ACM_AQUADS_A = 16'd384;

  // Ring buffer access port.
  localparam logic [WB_AW-1:0] VS_INDIRECT_A = 16'd512;

  // System registers.
  localparam logic [WB_AW-1:0] SYSTIME_A = 16'd8;
  localparam logic [WB_AW-1:0] CRASHSRC_A = 16'd12;
  localparam logic [WB_AW-1:0] CRASHVAL_A = 16'd13;
  localparam logic [WB_AW-1:0] LEVELSVALID_A = 16'd14;
  localparam logic [WB_AW-1:0] SYSCONFIG_A = 16'd576;

  // Flash window and the stored system configuration word.
  localparam logic [WB_AW-1:0] FLASH_A = 16'd1024;
  localparam logic [WB_AW-1:0] FLASH_SYSCONFIG_A = 16'hffff;

endpackage

//--- hdl/dma_seq_pkg.sv
package dma_seq_pkg;

  // Sequence modes of the decode stage.
  typedef enum logic [2:0] {
    MODE_FLASH     = 3'd0,
    MODE_LC        = 3'd1,
    MODE_ACM       = 3'd2,
    MODE_SYSCONFIG = 3'd3,
    MODE_DONE      = 3'd4
  } seq_mode_e;

  // How the result stage forms the next write word.
  typedef enum logic [1:0] {
    XF_PASS   = 2'd0,
    XF_THRESH = 2'd1,
    XF_SYSCFG = 2'd2,
    XF_CONST  = 2'd3
  } xform_e;

  // A bus word, or one ring buffer entry.
  // Bit 15 marks the last entry of the ring.
  typedef union packed {
    logic [dma_map_pkg::WB_DW-1:0] raw;
    struct packed {
      logic                          last;
      logic [dma_map_pkg::WB_DW-2:0] sample;
    } entry;
  } ring_word_u;

endpackage

//--- hdl/dma_step_decode.sv
module dma_step_decode #(
  parameter int LC_COUNT  = 64,
  parameter int ACM_COUNT = 40,
  parameter int DUMP_MAX  = 8191
) (
  input  logic                            wb_clk_i,
  input  logic                            soft_reset,
  input  logic                            start_i,
  input  logic                            dma_crash_i,
  input  logic                            xfer_done_i,
  input  logic                            ring_end_i,
  output logic                            req_o,
  output logic                            req_we_o,
  output logic [dma_map_pkg::WB_AW-1:0]   req_adr_o,
  output dma_seq_pkg::xform_e             xform_o,
  output logic [dma_map_pkg::WB_DW-1:0]   const_word_o,
  output logic                            dma_done_o
);
  import dma_map_pkg::*;
  import dma_seq_pkg::*;

  // Room for the crash header phases plus the whole dump.
  localparam int PW = $clog2(DUMP_MAX + 2);

  seq_mode_e        mode_q;
  seq_mode_e        nxt_mode;
  logic [PW-1:0]    progress_q;
  logic [PW-1:0]    nxt_progress;
  logic [2:0]       step_q;
  logic [2:0]       nxt_step;
  logic             issue_q;
  logic [WB_AW-1:0] idx;

  assign idx        = WB_AW'(progress_q);
  assign req_o      = issue_q;
  assign dma_done_o = (mode_q == MODE_DONE);

  always_comb begin
    req_we_o     = 1'b1;
    req_adr_o    = VS_INDIRECT_A;
    xform_o      = XF_PASS;
    const_word_o = '0;
    nxt_mode     = mode_q;
    nxt_progress = progress_q;
    nxt_step     = step_q + 3'd1;
    case (mode_q)
      MODE_FLASH: begin
        if (progress_q == '0) begin
          // Freeze the ring, marker, then three time words.
          case (step_q)
            3'd0: begin
              xform_o = XF_CONST;
            end
            3'd1: begin
              req_adr_o    = FLASH_A;
              xform_o      = XF_CONST;
              const_word_o = 16'hdead;
            end
            default: begin
              req_we_o  = step_q[0];
              req_adr_o = step_q[0] ? FLASH_A + WB_AW'(step_q[2:1])
                                    : SYSTIME_A + WB_AW'(step_q[2:1]) - 16'd1;
            end
          endcase
          if (step_q == 3'd7) begin
            nxt_progress = PW'(1);
            nxt_step     = '0;
          end
        end else if (progress_q == PW'(1)) begin
          // Crash source and value.
          req_we_o  = step_q[0];
          req_adr_o = step_q[0] ? FLASH_A + 16'd4 + WB_AW'(step_q[1])
                                : (step_q[1] ? CRASHVAL_A : CRASHSRC_A);
          if (step_q == 3'd3) begin
            nxt_progress = PW'(2);
            nxt_step     = '0;
          end
        end else begin
          case (step_q)
            3'd0: begin
              req_we_o = 1'b0;
            end
            3'd1: begin
              // Flash slot 6 onwards holds the dump.
              req_adr_o = FLASH_A + idx + 16'd4;
              if (!ring_end_i && progress_q != PW'(DUMP_MAX + 1)) begin
                nxt_progress = progress_q + 1'b1;
                nxt_step     = '0;
              end
            end
            default: begin
              // Let the ring buffer run again.
              xform_o      = XF_CONST;
              const_word_o = 16'hffff;
              nxt_mode     = MODE_LC;
              nxt_progress = '0;
              nxt_step     = '0;
            end
          endcase
        end
      end
      MODE_LC: begin
        req_we_o  = step_q[0];
        req_adr_o = step_q[0] ? LC_THRESHS_A + idx : FROM_LC_A + idx;
        xform_o   = XF_THRESH;
        if (step_q[0]) begin
          nxt_step     = '0;
          nxt_progress = progress_q + 1'b1;
          if (progress_q == PW'(LC_COUNT - 1)) begin
            nxt_mode     = MODE_ACM;
            nxt_progress = '0;
          end
        end
      end
      MODE_ACM: begin
        req_we_o  = step_q[0];
        req_adr_o = step_q[0] ? ACM_AQUADS_A + idx : FROM_ACM_A + idx;
        if (step_q[0]) begin
          nxt_step     = '0;
          nxt_progress = progress_q + 1'b1;
          if (progress_q == PW'(ACM_COUNT - 1)) begin
            nxt_mode     = MODE_SYSCONFIG;
            nxt_progress = '0;
          end
        end
      end
      MODE_SYSCONFIG: begin
        case (step_q)
          3'd0: begin
            req_we_o  = 1'b0;
            req_adr_o = FLASH_SYSCONFIG_A;
          end
          3'd1: begin
            req_adr_o = SYSCONFIG_A;
            xform_o   = XF_SYSCFG;
          end
          default: begin
            // Hard levels valid.
            req_adr_o    = LEVELSVALID_A;
            xform_o      = XF_CONST;
            const_word_o = 16'd1;
            nxt_mode     = MODE_DONE;
            nxt_step     = '0;
          end
        endcase
      end
      default: begin
        nxt_step = step_q;
      end
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (soft_reset) begin
      mode_q     <= MODE_DONE;
      progress_q <= '0;
      step_q     <= '0;
      issue_q    <= 1'b0;
    end else begin
      issue_q <= 1'b0;
      if (mode_q == MODE_DONE) begin
        if (start_i) begin
          mode_q     <= dma_crash_i ? MODE_FLASH : MODE_LC;
          progress_q <= '0;
          step_q     <= '0;
          issue_q    <= 1'b1;
        end
      end else if (xfer_done_i) begin
        mode_q     <= nxt_mode;
        progress_q <= nxt_progress;
        step_q     <= nxt_step;
        issue_q    <= (nxt_mode != MODE_DONE);
      end
    end
  end

endmodule

//--- hdl/wb_xfer_exec.sv
module wb_xfer_exec (
  input  logic                          wb_clk_i,
  input  logic                          soft_reset,
  input  logic                          req_i,
  input  logic                          req_we_i,
  input  logic [dma_map_pkg::WB_AW-1:0] req_adr_i,
  input  logic                          wb_ack_i,
  input  logic                          wb_err_i,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic                          wb_we_o,
  output logic [dma_map_pkg::WB_AW-1:0] wb_adr_o,
  output logic                          xfer_done_o
);

  // An error ends the cycle like an ack.
  assign xfer_done_o = wb_cyc_o && (wb_ack_i || wb_err_i);
  assign wb_stb_o    = wb_cyc_o;

  always_ff @(posedge wb_clk_i) begin
    if (soft_reset) begin
      wb_cyc_o <= 1'b0;
    end else if (req_i) begin
      wb_cyc_o <= 1'b1;
    end else if (xfer_done_o) begin
      wb_cyc_o <= 1'b0;
    end
  end

  // Held until the next request.
  always_ff @(posedge wb_clk_i) begin
    if (req_i) begin
      wb_we_o  <= req_we_i;
      wb_adr_o <= req_adr_i;
    end
  end

endmodule

//--- hdl/dma_data_result.sv
module dma_data_result (
  input  logic                          wb_clk_i,
  input  logic                          soft_reset,
  input  logic                          xfer_done_i,
  input  logic [dma_map_pkg::WB_DW-1:0] wb_dat_i,
  input  dma_seq_pkg::xform_e           xform_i,
  input  logic [dma_map_pkg::WB_DW-1:0] const_word_i,
  output logic [dma_map_pkg::WB_DW-1:0] wb_dat_o,
  output logic                          ring_end_o
);
  import dma_seq_pkg::*;

  ring_word_u rd_q;

  // Last word seen on the bus.
  always_ff @(posedge wb_clk_i) begin
    if (soft_reset) begin
      rd_q.raw <= '0;
    end else if (xfer_done_i) begin
      rd_q.raw <= wb_dat_i;
    end
  end

  assign ring_end_o = rd_q.entry.last;

  always_comb begin
    case (xform_i)
      XF_THRESH: begin
        // 0xff in the FROM disables the too-high check.
        if (rd_q.raw == 16'h00ff) begin
          wb_dat_o = 16'h0fff;
        end else begin
          wb_dat_o = rd_q.raw << 4;
        end
      end
      XF_SYSCFG: begin
        // Blank flash gives no valid config.
        if (rd_q.raw > 16'h00ff) begin
          wb_dat_o = '0;
        end else begin
          wb_dat_o = rd_q.raw;
        end
      end
      XF_CONST: begin
        wb_dat_o = const_word_i;
      end
      default: begin
        wb_dat_o = rd_q.raw;
      end
    endcase
  end

endmodule

//--- hdl/dma_engine.sv
module dma_engine #(
  parameter int LC_COUNT  = 64,
  parameter int ACM_COUNT = 40,
  parameter int DUMP_MAX  = 8191
) (
  input  logic                          wb_clk_i,
  input  logic                          soft_reset,
  input  logic                          start_i,
  input  logic                          dma_crash_i,
  input  logic                          wb_ack_i,
  input  logic                          wb_err_i,
  input  logic [dma_map_pkg::WB_DW-1:0] wb_dat_i,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic                          wb_we_o,
  output logic [dma_map_pkg::WB_AW-1:0] wb_adr_o,
  output logic [dma_map_pkg::WB_DW-1:0] wb_dat_o,
  output logic                          dma_done_o
);
  import dma_map_pkg::*;
  import dma_seq_pkg::*;

  logic             req;
  logic             req_we;
  logic [WB_AW-1:0] req_adr;
  xform_e           xform;
  logic [WB_DW-1:0] const_word;
  logic             xfer_done;
  logic             ring_end;

  dma_step_decode #(
    .LC_COUNT  (LC_COUNT),
    .ACM_COUNT (ACM_COUNT),
    .DUMP_MAX  (DUMP_MAX)
  ) u_decode (
    .wb_clk_i     (wb_clk_i),
    .soft_reset   (soft_reset),
    .start_i      (start_i),
    .dma_crash_i  (dma_crash_i),
    .xfer_done_i  (xfer_done),
    .ring_end_i   (ring_end),
    .req_o        (req),
    .req_we_o     (req_we),
    .req_adr_o    (req_adr),
    .xform_o      (xform),
    .const_word_o (const_word),
    .dma_done_o   (dma_done_o)
  );

  wb_xfer_exec u_exec (
    .wb_clk_i    (wb_clk_i),
    .soft_reset  (soft_reset),
    .req_i       (req),
    .req_we_i    (req_we),
    .req_adr_i   (req_adr),
    .wb_ack_i    (wb_ack_i),
    .wb_err_i    (wb_err_i),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_we_o     (wb_we_o),
    .wb_adr_o    (wb_adr_o),
    .xfer_done_o (xfer_done)
  );

  dma_data_result u_result (
    .wb_clk_i     (wb_clk_i),
    .soft_reset   (soft_reset),
    .xfer_done_i  (xfer_done),
    .wb_dat_i     (wb_dat_i),
    .xform_i      (xform),
    .const_word_i (const_word),
    .wb_dat_o     (wb_dat_o),
    .ring_end_o   (ring_end)
  );

endmodule

//--- verif/tb_clk_gen.sv
module tb_clk_gen #(
  parameter int PERIOD_NS = 8
) (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

//--- verif/wb_mem_model.sv
module wb_mem_model (
  input  logic                          wb_clk_i,
  input  logic                          soft_reset,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [dma_map_pkg::WB_AW-1:0] wb_adr_i,
  input  logic [dma_map_pkg::WB_DW-1:0] wb_dat_i,
  output logic                          wb_ack_o,
  output logic                          wb_err_o,
  output logic [dma_map_pkg::WB_DW-1:0] wb_dat_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import dma_map_pkg::*;
  import dma_seq_pkg::*;

  localparam int RING_LEN  = 8;
  localparam int RING_LAST = 5;

  logic [WB_DW-1:0] mem [0:65535];
  ring_word_u       ring [0:RING_LEN-1];
  int               ring_ptr;
  int               wait_cnt;
  integer           seed;

  initial begin
    seed     = 20;
    wb_ack_o = 1'b0;
    wb_err_o = 1'b0;
    wb_dat_o = '0;
    ring_ptr = 0;
    wait_cnt = 0;
    for (int a = 0; a < 65536; a++) begin
      mem[a] = 16'(a) ^ {8'(a), 8'(a >> 8)} ^ 16'h5a5a;
    end
    // Threshold bytes, every seventh one disabled.
    for (int i = 0; i < 64; i++) begin
      mem[FROM_LC_A + i] = (i % 7 == 3) ? 16'h00ff : 16'((i * 37 + 5) % 255);
    end
    for (int i = 0; i < RING_LEN; i++) begin
      ring[i].entry.last   = (i == RING_LAST);
      ring[i].entry.sample = 15'(i * 291 + 7);
    end
  end

  // Zero to two wait states per transfer.
  always @(posedge wb_clk_i) begin
    if (soft_reset) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      wait_cnt <= 0;
      ring_ptr <= 0;
    end else if (wb_ack_o || wb_err_o) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      wait_cnt <= $unsigned($random(seed)) % 3;
    end else if (wb_cyc_i && wb_stb_i) begin
      if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1;
      end else begin
        // System registers answer with err instead of ack.
        if (wb_adr_i >= SYSTIME_A && wb_adr_i <= LEVELSVALID_A) begin
          wb_err_o <= 1'b1;
        end else begin
          wb_ack_o <= 1'b1;
        end
        if (wb_we_i && wb_adr_i == VS_INDIRECT_A) begin
          // Zero freezes the ring and rewinds it.
          if (wb_dat_i == '0) begin
            ring_ptr <= 0;
          end
        end else if (wb_we_i) begin
          mem[wb_adr_i] <= wb_dat_i;
        end else if (wb_adr_i == VS_INDIRECT_A) begin
          wb_dat_o <= ring[ring_ptr % RING_LEN].raw;
          ring_ptr <= ring_ptr + 1;
        end else begin
          wb_dat_o <= mem[wb_adr_i];
        end
      end
    end
  end

endmodule

//--- verif/dma_props.sv
module dma_props #(
  parameter int RING_ENTRIES = 6
) (
  input logic                          wb_clk_i,
  input logic                          soft_reset,
  input logic                          start_i,
  input logic                          dma_crash_i,
  input logic                          wb_cyc_o,
  input logic                          wb_stb_o,
  input logic                          wb_we_o,
  input logic [dma_map_pkg::WB_AW-1:0] wb_adr_o,
  input logic [dma_map_pkg::WB_DW-1:0] wb_dat_o,
  input logic                          wb_ack_i,
  input logic                          wb_err_i,
  input logic [dma_map_pkg::WB_DW-1:0] wb_dat_i,
  input logic                          dma_done_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import dma_map_pkg::*;

  logic [WB_DW-1:0] last_rd;
  logic             crash_run;
  int               xfer_n;
  int               dump_n;
  logic             sys_seen;
  logic             lv_seen;
  int               fail_count;
  logic             xfer;
  logic             wr;

  assign xfer = wb_cyc_o && (wb_ack_i || wb_err_i);
  assign wr   = xfer && wb_we_o;

  function automatic logic [WB_DW-1:0] thresh_of(input logic [WB_DW-1:0] w);
    if (w == 16'h00ff) begin
      return 16'h0fff;
    end
    return {w[11:0], 4'h0};
  endfunction

  function automatic logic [WB_DW-1:0] syscfg_of(input logic [WB_DW-1:0] w);
    return (w[15:8] != 8'h00) ? 16'h0000 : w;
  endfunction

  initial fail_count = 0;

  // Run bookkeeping.
  always @(posedge wb_clk_i) begin
    if (soft_reset) begin
      last_rd   <= '0;
      crash_run <= 1'b0;
      xfer_n    <= 0;
      dump_n    <= 0;
      sys_seen  <= 1'b0;
      lv_seen   <= 1'b0;
    end else begin
      if (start_i && dma_done_o) begin
        crash_run <= dma_crash_i;
        xfer_n    <= 0;
        dump_n    <= 0;
        sys_seen  <= 1'b0;
        lv_seen   <= 1'b0;
      end
      if (xfer) begin
        xfer_n <= xfer_n + 1;
        if (!wb_we_o) begin
          last_rd <= wb_dat_i;
        end
      end
      // Dump entries go to flash slot 6 onwards.
      if (wr && crash_run && wb_adr_o >= FLASH_A + 16'd6) begin
        dump_n <= dump_n + 1;
      end
      if (wr && wb_adr_o == SYSCONFIG_A) begin
        sys_seen <= 1'b1;
      end
      if (wr && wb_adr_o == LEVELSVALID_A) begin
        lv_seen <= 1'b1;
      end
    end
  end

  stb_follows_cyc: assert property (@(posedge wb_clk_i) wb_stb_o == wb_cyc_o)
    else begin
      fail_count++;
      $error("FAILED wb_stb_o got %h expected %h", $sampled(wb_stb_o), $sampled(wb_cyc_o));
    end

  bus_held: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    wb_cyc_o && !wb_ack_i && !wb_err_i |=>
      $stable(wb_adr_o) && $stable(wb_we_o) && (!wb_we_o || $stable(wb_dat_o)))
    else begin
      fail_count++;
      $error("bus signals changed while the cycle waited for its ack");
    end

  idle_after_reset: assert property (@(posedge wb_clk_i)
    $fell(soft_reset) |-> dma_done_o && !wb_cyc_o)
    else begin
      fail_count++;
      $error("engine not idle and done when reset was released");
    end

  lc_thresh: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    wr && wb_adr_o >= LC_THRESHS_A && wb_adr_o < ACM_AQUADS_A |->
      wb_dat_o == thresh_of(last_rd))
    else begin
      fail_count++;
      $error("FAILED wb_dat_o got %h expected %h", $sampled(wb_dat_o),
             thresh_of($sampled(last_rd)));
    end

  sysconfig_word: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    wr && wb_adr_o == SYSCONFIG_A |-> wb_dat_o == syscfg_of(last_rd))
    else begin
      fail_count++;
      $error("FAILED wb_dat_o got %h expected %h", $sampled(wb_dat_o),
             syscfg_of($sampled(last_rd)));
    end

  levels_value: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    wr && wb_adr_o == LEVELSVALID_A |-> wb_dat_o == 16'h0001)
    else begin
      fail_count++;
      $error("FAILED wb_dat_o got %h expected %h", $sampled(wb_dat_o), 16'h0001);
    end

  levels_order: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    wr && wb_adr_o == LEVELSVALID_A |-> sys_seen)
    else begin
      fail_count++;
      $error("levels valid was written before the system configuration word");
    end

  done_last: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    $rose(dma_done_o) |-> lv_seen)
    else begin
      fail_count++;
      $error("dma_done_o rose before levels valid was written");
    end

  crash_freeze: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    crash_run && xfer && xfer_n == 0 |->
      wb_we_o && wb_adr_o == VS_INDIRECT_A && wb_dat_o == '0)
    else begin
      fail_count++;
      $error("crash sequence did not start by writing 0 to the ring port");
    end

  crash_marker: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    crash_run && xfer && xfer_n == 1 |->
      wb_we_o && wb_adr_o == FLASH_A && wb_dat_o == 16'hdead)
    else begin
      fail_count++;
      $error("crash marker was not written to the start of flash");
    end

  dump_length: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    crash_run && wr && wb_adr_o == VS_INDIRECT_A && xfer_n != 0 |->
      dump_n == RING_ENTRIES)
    else begin
      fail_count++;
      $error("FAILED dump_n got %h expected %h", $sampled(dump_n), RING_ENTRIES);
    end

  ring_release: assert property (@(posedge wb_clk_i) disable iff (soft_reset)
    crash_run && wr && wb_adr_o == VS_INDIRECT_A && xfer_n != 0 |->
      wb_dat_o == 16'hffff)
    else begin
      fail_count++;
      $error("FAILED wb_dat_o got %h expected %h", $sampled(wb_dat_o), 16'hffff);
    end

endmodule

//--- verif/tb_dma.sv
module tb_dma;
  timeunit 1ns;
  timeprecision 100ps;
  import dma_map_pkg::*;

  // Two runs of about 250 transfers, up to 5 cycles each, with margin.
  localparam int MAX_CYCLES = 20000;

  logic             wb_clk;
  logic             soft_reset;
  logic             start;
  logic             dma_crash;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [WB_AW-1:0] wb_adr;
  logic [WB_DW-1:0] wb_dat_w;
  logic [WB_DW-1:0] wb_dat_r;
  logic             wb_ack;
  logic             wb_err;
  logic             dma_done;
  int               cycles;

  tb_clk_gen #(.PERIOD_NS(8)) u_clk (.clk_o(wb_clk));

  dma_engine #(
    .LC_COUNT  (64),
    .ACM_COUNT (40),
    .DUMP_MAX  (8191)
  ) DUT (
    .wb_clk_i    (wb_clk),
    .soft_reset  (soft_reset),
    .start_i     (start),
    .dma_crash_i (dma_crash),
    .wb_ack_i    (wb_ack),
    .wb_err_i    (wb_err),
    .wb_dat_i    (wb_dat_r),
    .wb_cyc_o    (wb_cyc),
    .wb_stb_o    (wb_stb),
    .wb_we_o     (wb_we),
    .wb_adr_o    (wb_adr),
    .wb_dat_o    (wb_dat_w),
    .dma_done_o  (dma_done)
  );

  wb_mem_model u_mem (
    .wb_clk_i   (wb_clk),
    .soft_reset (soft_reset),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_adr_i   (wb_adr),
    .wb_dat_i   (wb_dat_w),
    .wb_ack_o   (wb_ack),
    .wb_err_o   (wb_err),
    .wb_dat_o   (wb_dat_r)
  );

  bind dma_engine dma_props u_props (
    .wb_clk_i    (wb_clk_i),
    .soft_reset  (soft_reset),
    .start_i     (start_i),
    .dma_crash_i (dma_crash_i),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_we_o     (wb_we_o),
    .wb_adr_o    (wb_adr_o),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_i    (wb_ack_i),
    .wb_err_i    (wb_err_i),
    .wb_dat_i    (wb_dat_i),
    .dma_done_o  (dma_done_o)
  );

  // Start one sequence and wait until the engine is done again.
  task automatic run_sequence(input logic crash);
    @(posedge wb_clk);
    start     <= 1'b1;
    dma_crash <= crash;
    @(posedge wb_clk);
    start     <= 1'b0;
    dma_crash <= 1'b0;
    @(negedge wb_clk);
    while (!dma_done) begin
      @(negedge wb_clk);
    end
  endtask

  initial begin
    soft_reset = 1'b1;
    start      = 1'b0;
    dma_crash  = 1'b0;
    repeat (10) @(posedge wb_clk);
    soft_reset <= 1'b0;
    run_sequence(1'b1);
    // Valid config word for the second boot.
    @(negedge wb_clk);
    u_mem.mem[FLASH_SYSCONFIG_A] = 16'h005a;
    run_sequence(1'b0);
    repeat (4) @(posedge wb_clk);
    $display("assertion failures: %0d", DUT.u_props.fail_count);
    if (DUT.u_props.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge wb_clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the engine never finished", cycles);
    $display("assertion failures: %0d", DUT.u_props.fail_count);
    $display("test failed");
    $finish;
  end

endmodule

//--- sim.f
hdl/dma_map_pkg.sv
hdl/dma_seq_pkg.sv
hdl/dma_step_decode.sv
hdl/wb_xfer_exec.sv
hdl/dma_data_result.sv
hdl/dma_engine.sv
verif/tb_clk_gen.sv
verif/wb_mem_model.sv
verif/dma_props.sv
verif/tb_dma.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dma
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it, check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
